// ==== design/bus_pkg.sv ====
// Bus bundles only; CPU strobes are active low except addr_strobe, host data is one byte
`default_nettype none

package bus_pkg;

  import mem_map_pkg::*;

  // ======================================================================
  // CPU side
  // ======================================================================
  typedef struct packed {
    logic [ADDR_W-1:0] addr;        // Word address
    logic [DATA_W-1:0] wdata;
    logic              we_n;
    logic              oe_n;
    logic              lb_n;        // Bits 7:0
    logic              ub_n;        // Bits 15:8
    logic              addr_strobe; // One pulse per access
  } cpu_bus_t;

  // ======================================================================
  // Host side (SPI slave word accesses)
  // ======================================================================
  typedef struct packed {
    logic                   wr;
    logic                   rd;
    logic [HOST_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]      data;
  } host_acc_t;

  // Held until the bootloader acknowledges
  typedef struct packed {
    logic [HOST_ADDR_W-1:0] addr;
    logic [BYTE_W-1:0]      wdata;
    logic                   read_rq;
    logic                   write_rq;
  } boot_req_t;

  // Toward the SDRAM controller
  typedef struct packed {
    logic              strobe;   // Single cycle
    logic              write_n;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } sdram_req_t;

endpackage

`default_nettype wire

// ==== design/console_memory.sv ====
// Synchronous-read RAMs, read data one cycle after address; no init, contents undefined at start
`timescale 1ns/1ps
`default_nettype none

module console_memory
(
  input  logic                           clk,
  input  bus_pkg::cpu_bus_t              i_cpu,
  input  mem_map_pkg::region_e           i_region,
  input  logic [mem_map_pkg::DATA_W-1:0] i_sdram_rdata,
  output logic [mem_map_pkg::DATA_W-1:0] o_rdata
);
  import mem_map_pkg::*;

  localparam int PAD_DEPTH  = 1 << PAD_AW;
  localparam int GEXT_DEPTH = 1 << GEXT_AW;

  // Byte lanes kept as packed pairs, lane 0 is bits 7:0
  logic [1:0][7:0]    pad_ram  [0:PAD_DEPTH-1];
  logic [1:0][7:0]    gext_ram [0:GEXT_DEPTH-1];
  logic [PAD_AW-1:0]  pad_addr;
  logic [GEXT_AW-1:0] gext_addr;
  logic [1:0]         lane_en;
  logic [1:0]         pad_we;
  logic [1:0]         gext_we;
  logic [DATA_W-1:0]  pad_q;
  logic [DATA_W-1:0]  gext_q;
  region_e            region_q;

  assign pad_addr  = i_cpu.addr[PAD_AW-1:0];
  assign gext_addr = i_cpu.addr[GEXT_AW-1:0];  // Slots 3..6 alias to unique 14-bit words
  assign lane_en   = {~i_cpu.ub_n, ~i_cpu.lb_n};
  assign pad_we    = (i_region == REG_PAD  && !i_cpu.we_n) ? lane_en : 2'b00;
  assign gext_we   = (i_region == REG_GEXT && !i_cpu.we_n) ? lane_en : 2'b00;

  // ======================================================================
  // RAM write and registered read
  // ======================================================================
  always_ff @(posedge clk)
  begin
    for (int lane = 0; lane < 2; lane++)
    begin
      if (pad_we[lane])
        pad_ram[pad_addr][lane] <= i_cpu.wdata[lane*8 +: 8];
      if (gext_we[lane])
        gext_ram[gext_addr][lane] <= i_cpu.wdata[lane*8 +: 8];
    end
    pad_q    <= pad_ram[pad_addr];   // Old data on a write cycle
    gext_q   <= gext_ram[gext_addr];
    region_q <= i_region;            // Steers the mux with its data
  end

  // Read data mux
  always_comb
  begin
    case (region_q)
      REG_PAD:   o_rdata = pad_q;
      REG_GEXT:  o_rdata = gext_q;
      REG_SDRAM: o_rdata = i_sdram_rdata;  // Held acknowledge data
      default:   o_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/host_bridge.sv ====
// Host accesses are single pulses; a new RAM request while one is pending overwrites its address
`timescale 1ns/1ps
`default_nettype none

module host_bridge
(
  input  logic                           clk,
  input  logic                           i_reset,
  input  bus_pkg::host_acc_t             i_host,
  input  logic                           i_boot_rd_ack,
  input  logic                           i_boot_wr_ack,
  input  logic [mem_map_pkg::BYTE_W-1:0] i_boot_rdata,
  output bus_pkg::boot_req_t             o_boot,
  output logic [mem_map_pkg::BYTE_W-1:0] o_host_rdata,
  output logic [mem_map_pkg::BYTE_W-1:0] o_cpu_control
);
  import mem_map_pkg::*;

  logic                   ctrl_access;
  logic                   ram_access;
  logic [HOST_ADDR_W-1:0] boot_addr;
  logic [BYTE_W-1:0]      boot_wdata;
  logic                   read_rq;
  logic                   write_rq;

  // Address tag split
  assign ctrl_access = (i_host.addr[HOST_ADDR_W-1 -: 8] == CPU_CTRL_TAG);
  assign ram_access  = (i_host.addr[HOST_ADDR_W-1 -: 4] == HOST_RAM_TAG);

  // ======================================================================
  // Control register and request flags
  // ======================================================================
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      o_cpu_control <= '0;
      read_rq       <= 1'b0;
      write_rq      <= 1'b0;
    end
    else
    begin
      if (i_host.wr && ctrl_access)
        o_cpu_control <= i_host.data;
      if (i_boot_rd_ack)
        read_rq <= 1'b0;          // Drops on the sampling edge
      else if (i_host.rd && ram_access)
        read_rq <= 1'b1;
      if (i_boot_wr_ack)
        write_rq <= 1'b0;
      else if (i_host.wr && ram_access)
        write_rq <= 1'b1;
    end
  end

  // Address, write byte and returned byte
  always_ff @(posedge clk)
  begin
    if ((i_host.rd || i_host.wr) && ram_access)
      boot_addr <= i_host.addr;
    if (i_host.wr && ram_access)
      boot_wdata <= i_host.data;
    if (i_boot_rd_ack)
      o_host_rdata <= i_boot_rdata; // Same edge as read_rq falls
  end

  always_comb
  begin
    o_boot.addr     = boot_addr;
    o_boot.wdata    = boot_wdata;
    o_boot.read_rq  = read_rq;
    o_boot.write_rq = write_rq;
  end

endmodule

`default_nettype wire

// ==== design/mem_map_pkg.sv ====
// Console map is word addressed (23 bits); only scratchpad and GROM extension are on chip
`default_nettype none

package mem_map_pkg;

  // ======================================================================
  // Widths and sizes
  // ======================================================================
  localparam int ADDR_W           = 23;   // CPU word address
  localparam int DATA_W           = 16;   // CPU data word
  localparam int BYTE_W           = 8;    // Host and bootloader data
  localparam int HOST_ADDR_W      = 32;   // Host side byte address
  localparam int PAD_AW           = 9;    // 512 words of scratchpad
  localparam int GEXT_AW          = 14;   // 16K words of GROM extension
  localparam int RESET_DELAY_BITS = 24;
  localparam int SDRAM_WAIT_LIMIT = 100;  // Busy timeout, cycles
  localparam int WAIT_CNT_W       = 7;    // Must hold SDRAM_WAIT_LIMIT

  // ======================================================================
  // Decode constants, compared against upper word address bits
  // ======================================================================
  localparam logic [7:0]  CPU_CTRL_TAG = 8'hFF;    // Host addr 31:24
  localparam logic [3:0]  HOST_RAM_TAG = 4'h0;     // Host addr 31:28
  localparam logic [13:0] PAD_PAGE     = 14'h0040; // Bits 22:9
  localparam logic [10:0] ROM_PAGE     = 11'h000;  // Console ROM, bits 22:12
  localparam logic [10:0] LOEXP_PAGE   = 11'h001;  // Low expansion RAM
  localparam logic [10:0] HIEXP_PAGE   = 11'h005;  // High expansion, lower 8K
  localparam logic [9:0]  HIEXP_TOP    = 10'h003;  // High expansion, upper 16K, bits 22:13
  localparam logic [7:0]  GROM_PAGE    = 8'h01;    // GROM space, bits 22:15
  localparam logic [7:0]  DSR_PAGE     = 8'h03;    // DSR ROM area
  localparam logic [2:0]  GEXT_FIRST   = 3'd3;     // Bits 14:12 window
  localparam logic [2:0]  GEXT_LAST    = 3'd6;
  localparam logic [3:0]  SAMS_PAGE    = 4'h1;     // Bits 22:19
  localparam logic [2:0]  CART_PAGE    = 3'h1;     // Bits 22:20
  localparam logic [2:0]  SPARE_PAGE   = 3'h2;

  typedef enum logic [1:0] {
    REG_NONE  = 2'd0,  // Unmapped, reads zero
    REG_PAD   = 2'd1,
    REG_GEXT  = 2'd2,
    REG_SDRAM = 2'd3
  } region_e;

endpackage

`default_nettype wire

// ==== design/region_decoder.sv ====
// Pure combinational decode; scratchpad wins over GROM extension, which wins over SDRAM
`timescale 1ns/1ps
`default_nettype none

module region_decoder
(
  input  logic [mem_map_pkg::ADDR_W-1:0] i_addr,
  output mem_map_pkg::region_e           o_region
);
  import mem_map_pkg::*;

  logic pad_sel;
  logic grom_sel;
  logic gext_sel;
  logic sdram_sel;
  logic [2:0] grom_bank;

  assign grom_bank = i_addr[14:12];                    // GROM 8K slot
  assign pad_sel   = (i_addr[ADDR_W-1:9] == PAD_PAGE);
  assign grom_sel  = (i_addr[ADDR_W-1:15] == GROM_PAGE);
  assign gext_sel  = grom_sel && (grom_bank >= GEXT_FIRST) && (grom_bank <= GEXT_LAST);

  // Everything that lives in SDRAM
  assign sdram_sel = (i_addr[ADDR_W-1:12] == ROM_PAGE)    // Console ROM
                  || (i_addr[ADDR_W-1:12] == LOEXP_PAGE)  // 2000..3FFF
                  || (i_addr[ADDR_W-1:12] == HIEXP_PAGE)  // A000..BFFF
                  || (i_addr[ADDR_W-1:13] == HIEXP_TOP)   // C000..FFFF
                  || (grom_sel && !gext_sel)              // Console GROM
                  || (i_addr[ADDR_W-1:15] == DSR_PAGE)
                  || (i_addr[ADDR_W-1:19] == SAMS_PAGE)   // 1M..2M
                  || (i_addr[ADDR_W-1:20] == CART_PAGE)   // Cartridges
                  || (i_addr[ADDR_W-1:20] == SPARE_PAGE);

  always_comb
  begin
    if (pad_sel)
      o_region = REG_PAD;
    else if (gext_sel)
      o_region = REG_GEXT;
    else if (sdram_sel)
      o_region = REG_SDRAM;
    else
      o_region = REG_NONE;  // Unmapped
  end

endmodule

`default_nettype wire

// ==== design/reset_sequencer.sv ====
// Reset held for 2^(p_delay_bits-1) cycles after lock; button is not debounced here
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer
#(
  parameter int p_delay_bits = 24
)
(
  input  logic clk,
  input  logic i_reset,
  input  logic i_pll_locked,
  input  logic i_btn_reset_n,
  output logic o_sys_reset
);

  logic [p_delay_bits-1:0] delay_cnt;
  logic                    delay_done;

  assign delay_done = delay_cnt[p_delay_bits-1]; // Top bit ends the wait

  always_ff @(posedge clk)
  begin
    if (i_reset || !i_pll_locked)
    begin
      delay_cnt   <= '0;   // Restart on any loss of lock
      o_sys_reset <= 1'b1;
    end
    else
    begin
      if (!delay_done)
        delay_cnt <= delay_cnt + 1'b1; // Saturates at top bit
      o_sys_reset <= ~(i_btn_reset_n & delay_done);
    end
  end

endmodule

`default_nettype wire

// ==== design/sdram_wait_gen.sv ====
// CPU must hold its address while busy; p_wait_limit has to fit in WAIT_CNT_W bits
`timescale 1ns/1ps
`default_nettype none

module sdram_wait_gen
#(
  parameter int p_wait_limit = mem_map_pkg::SDRAM_WAIT_LIMIT
)
(
  input  logic                           clk,
  input  logic                           i_reset,
  input  bus_pkg::cpu_bus_t              i_cpu,
  input  mem_map_pkg::region_e           i_region,
  input  logic                           i_sdram_ack,
  input  logic [mem_map_pkg::DATA_W-1:0] i_sdram_rdata,
  output bus_pkg::sdram_req_t            o_sdram,
  output logic                           o_busy,
  output logic [mem_map_pkg::DATA_W-1:0] o_sdram_rdata
);
  import mem_map_pkg::*;

  logic                  start;      // Qualified CPU strobe, combinational
  logic                  strobe_q;   // One cycle later, to the controller
  logic [WAIT_CNT_W-1:0] busy_cnt;
  logic                  req_write_n;
  logic [ADDR_W-1:0]     req_addr;
  logic [DATA_W-1:0]     req_wdata;

  assign start  = i_cpu.addr_strobe && (i_region == REG_SDRAM) && !o_busy;
  assign o_busy = |busy_cnt;

  // ======================================================================
  // Strobe delay and busy timeout
  // ======================================================================
  always_ff @(posedge clk)
  begin
    if (i_reset)
    begin
      strobe_q <= 1'b0;
      busy_cnt <= '0;
    end
    else
    begin
      strobe_q <= start;
      if (i_sdram_ack)
        busy_cnt <= '0;                          // Ack ends the wait
      else if (start)
        busy_cnt <= WAIT_CNT_W'(p_wait_limit);
      else if (o_busy)
        busy_cnt <= busy_cnt - 1'b1;             // Timeout countdown
    end
  end

  // Request fields and returned word
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      req_write_n <= i_cpu.we_n;
      req_addr    <= i_cpu.addr;
      req_wdata   <= i_cpu.wdata;
    end
    if (i_sdram_ack)
      o_sdram_rdata <= i_sdram_rdata;  // Held until next ack
  end

  always_comb
  begin
    o_sdram.strobe  = strobe_q;
    o_sdram.write_n = req_write_n;
    o_sdram.addr    = req_addr;
    o_sdram.wdata   = req_wdata;
  end

endmodule

`default_nettype wire

// ==== design/ti_mem_subsys.sv ====
// Single clock domain; SDRAM controller and bootloader sit outside and answer the handshakes
`timescale 1ns/1ps
`default_nettype none

module ti_mem_subsys
#(
  parameter int p_reset_delay_bits = mem_map_pkg::RESET_DELAY_BITS
)
(
  input  logic                           clk,
  input  logic                           i_reset,
  input  logic                           i_pll_locked,
  input  logic                           i_btn_reset_n,
  input  bus_pkg::cpu_bus_t              i_cpu,
  input  bus_pkg::host_acc_t             i_host,
  input  logic                           i_boot_rd_ack,
  input  logic                           i_boot_wr_ack,
  input  logic [mem_map_pkg::BYTE_W-1:0] i_boot_rdata,
  input  logic                           i_sdram_ack,
  input  logic [mem_map_pkg::DATA_W-1:0] i_sdram_rdata,
  output logic                           o_sys_reset,
  output logic [mem_map_pkg::DATA_W-1:0] o_rdata,
  output logic                           o_busy,
  output bus_pkg::sdram_req_t            o_sdram,
  output bus_pkg::boot_req_t             o_boot,
  output logic [mem_map_pkg::BYTE_W-1:0] o_host_rdata,
  output logic [mem_map_pkg::BYTE_W-1:0] o_cpu_control
);
  import mem_map_pkg::*;

  region_e           region;       // Current CPU access region
  logic [DATA_W-1:0] sdram_rdata;  // Held SDRAM read word

  // ======================================================================
  // Reset and host side
  // ======================================================================
  reset_sequencer #(.p_delay_bits(p_reset_delay_bits)) i_reset_sequencer (
    .clk           (clk),
    .i_reset       (i_reset),
    .i_pll_locked  (i_pll_locked),
    .i_btn_reset_n (i_btn_reset_n),
    .o_sys_reset   (o_sys_reset)
  );

  host_bridge i_host_bridge (
    .clk           (clk),
    .i_reset       (o_sys_reset),
    .i_host        (i_host),
    .i_boot_rd_ack (i_boot_rd_ack),
    .i_boot_wr_ack (i_boot_wr_ack),
    .i_boot_rdata  (i_boot_rdata),
    .o_boot        (o_boot),
    .o_host_rdata  (o_host_rdata),
    .o_cpu_control (o_cpu_control)
  );

  // ======================================================================
  // CPU memory path
  // ======================================================================
  region_decoder i_region_decoder (
    .i_addr   (i_cpu.addr),
    .o_region (region)
  );

  console_memory i_console_memory (
    .clk           (clk),
    .i_cpu         (i_cpu),
    .i_region      (region),
    .i_sdram_rdata (sdram_rdata),
    .o_rdata       (o_rdata)
  );

  sdram_wait_gen #(.p_wait_limit(SDRAM_WAIT_LIMIT)) i_sdram_wait_gen (
    .clk           (clk),
    .i_reset       (o_sys_reset),
    .i_cpu         (i_cpu),
    .i_region      (region),
    .i_sdram_ack   (i_sdram_ack),
    .i_sdram_rdata (i_sdram_rdata),
    .o_sdram       (o_sdram),
    .o_busy        (o_busy),
    .o_sdram_rdata (sdram_rdata)
  );

endmodule

`default_nettype wire

// ==== flist.f ====
design/mem_map_pkg.sv
design/bus_pkg.sv
design/reset_sequencer.sv
design/host_bridge.sv
design/region_decoder.sv
design/console_memory.sv
design/sdram_wait_gen.sv
design/ti_mem_subsys.sv
test/ti_mem_subsys_assert.sv
test/tb_ti_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_ti_mem_subsys -f flist.f

./obj_dir/Vtb_ti_mem_subsys > sim.log 2>&1 || true
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
  exit 1
fi
grep -q "=== PASS ===" sim.log

// ==== test/stim_input.txt ====
// Columns: opcode, address, data, expected (lane mask on CPU writes, bit 0 = low byte)
// Opcodes: 0 CPU wr, 1 CPU rd, 2 SDRAM wr, 3 SDRAM rd, 4 host wr, 5 host rd, 6 button, F end
0 00008000 ABCD 3
0 00008000 0012 1
0 00008000 5600 2
1 00008000 0000 5612
0 000081FF FFFF 3
0 000081FF 0000 2
1 000081FF 0000 00FF
0 0000B000 1357 3
0 0000EFFF 2468 3
1 0000B000 0000 1357
1 0000EFFF 0000 2468
2 0000F000 CAFE 3
3 0000F000 0000 CAFE
1 00040000 0000 0000
1 007F0000 0000 0000
2 00001234 BEEF 3
2 00080010 0F0F 3
3 00001234 0000 BEEF
3 00080010 0000 0F0F
4 FF000000 005A 005A
4 00000123 00A5 0000
5 00000456 0000 0056
6 00000000 0002 0000
F 00000000 0000 0000

// ==== test/tb_ti_mem_subsys.sv ====
// Must run from the project root to find test/stim_input.txt; SDRAM and bootloader are models
`timescale 1ns/1ps
`default_nettype none

module tb_ti_mem_subsys;
  import mem_map_pkg::*;
  import bus_pkg::*;

  localparam int DELAY_BITS   = 4;
  localparam int RESET_CYCLES = 4 + (1 << (DELAY_BITS - 1)) + 8; // Reset, delay, slack
  localparam int MAX_LINES    = 64;

  typedef enum logic [3:0] {
    OP_CPU_WR  = 4'h0, OP_CPU_RD  = 4'h1,  // On-chip RAM
    OP_SD_WR   = 4'h2, OP_SD_RD   = 4'h3,  // SDRAM region
    OP_HOST_WR = 4'h4, OP_HOST_RD = 4'h5,
    OP_BUTTON  = 4'h6, OP_END     = 4'hF
  } op_e;

  logic              clk;
  logic              reset;
  logic              pll_locked;
  logic              btn_reset_n;
  cpu_bus_t          cpu;
  host_acc_t         host;
  logic              boot_rd_ack = 1'b0;  // Bootloader model outputs
  logic              boot_wr_ack = 1'b0;
  logic [BYTE_W-1:0] boot_rdata  = '0;
  logic              sdram_ack   = 1'b0;  // SDRAM model outputs
  logic [DATA_W-1:0] sdram_rdata = '0;
  logic              sys_reset;
  logic [DATA_W-1:0] rdata;
  logic              busy;
  sdram_req_t        sdram;
  boot_req_t         boot;
  logic [BYTE_W-1:0] host_rdata;
  logic [BYTE_W-1:0] cpu_control;

  logic [31:0]       stim [0:4*MAX_LINES-1];      // Four columns per line
  logic [DATA_W-1:0] sdram_mem [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] sd_addr;                      // Request being served
  integer            seed        = 32'h9875;
  int                sdram_wait  = 0;
  int                strobe_count = 0;
  int                ack_count   = 0;
  int                boot_wait   = 0;
  int                cycle_count = 0;
  int                cycle_limit = 100000;         // Replaced once the file is read

  ti_mem_subsys #(.p_reset_delay_bits(DELAY_BITS)) i_ti_mem_subsys (
    .clk (clk), .i_reset (reset), .i_pll_locked (pll_locked),
    .i_btn_reset_n (btn_reset_n), .i_cpu (cpu), .i_host (host),
    .i_boot_rd_ack (boot_rd_ack), .i_boot_wr_ack (boot_wr_ack), .i_boot_rdata (boot_rdata),
    .i_sdram_ack (sdram_ack), .i_sdram_rdata (sdram_rdata),
    .o_sys_reset (sys_reset), .o_rdata (rdata), .o_busy (busy), .o_sdram (sdram),
    .o_boot (boot), .o_host_rdata (host_rdata), .o_cpu_control (cpu_control)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  // ====================================================================
  // Run limit
  // ====================================================================
  always @(posedge clk)
  begin
    cycle_count = cycle_count + 1;
    if (cycle_count > cycle_limit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("=== FAIL ===");
      $fatal(1, "run stopped on timeout");
    end
  end

  // Fill word for unwritten addresses mixes all address bits
  function automatic logic [DATA_W-1:0] fill_word(input logic [ADDR_W-1:0] addr);
    return addr[15:0] ^ {addr[22:16], addr[22:14]};
  endfunction

  // ====================================================================
  // SDRAM model acks 1 to 20 cycles after the strobe
  // ====================================================================
  always @(negedge clk)
  begin
    sdram_ack <= 1'b0;
    if (sdram.strobe)
    begin
      strobe_count <= strobe_count + 1;
      sd_addr      <= sdram.addr;
      if (!sdram.write_n)
        sdram_mem[sdram.addr] = sdram.wdata;   // Stored at request time
      sdram_wait <= 1 + ($unsigned($random(seed)) % 20);
    end
    else if (sdram_wait == 1)
    begin
      sdram_wait  <= 0;
      sdram_ack   <= 1'b1;
      ack_count   <= ack_count + 1;
      sdram_rdata <= sdram_mem.exists(sd_addr) ? sdram_mem[sd_addr] : fill_word(sd_addr);
    end
    else if (sdram_wait > 1)
      sdram_wait <= sdram_wait - 1;
  end

  // Bootloader model answers in 2 cycles with the address low byte
  always @(negedge clk)
  begin
    boot_rd_ack <= 1'b0;
    boot_wr_ack <= 1'b0;
    if ((boot.read_rq || boot.write_rq) && !boot_rd_ack && !boot_wr_ack)
    begin
      if (boot_wait == 1)
      begin
        boot_wait   <= 0;
        boot_rd_ack <= boot.read_rq;
        boot_wr_ack <= boot.write_rq;
        boot_rdata  <= boot.addr[7:0];
      end
      else
        boot_wait <= boot_wait + 1;
    end
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("=== FAIL ===");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic cpu_idle();
    cpu      = '0;
    cpu.we_n = 1'b1;
    cpu.oe_n = 1'b1;
    cpu.lb_n = 1'b1;
    cpu.ub_n = 1'b1;
  endtask

  // Aux holds the lane mask on writes and the expected word on reads
  task automatic cpu_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, input logic [31:0] aux);
    cpu.addr        = addr[ADDR_W-1:0];
    cpu.wdata       = data[DATA_W-1:0];
    cpu.we_n        = !wr;
    cpu.oe_n        = wr;
    cpu.lb_n        = wr ? !aux[0] : 1'b0;
    cpu.ub_n        = wr ? !aux[1] : 1'b0;
    cpu.addr_strobe = 1'b1;
    @(negedge clk);
    if (!wr)
      check_value("o_rdata", rdata, aux);   // One cycle after the address
    check_value("o_busy", busy, 0);
    cpu_idle();
  endtask

  task automatic sdram_access(input logic wr, input logic [31:0] addr,
                              input logic [31:0] data, input logic [31:0] expected);
    int strobes_before;
    int acks_before;
    strobes_before  = strobe_count;
    acks_before     = ack_count;
    cpu.addr        = addr[ADDR_W-1:0];
    cpu.wdata       = data[DATA_W-1:0];
    cpu.we_n        = !wr;
    cpu.oe_n        = wr;
    cpu.lb_n        = 1'b0;
    cpu.ub_n        = 1'b0;
    cpu.addr_strobe = 1'b1;
    @(negedge clk);
    cpu.addr_strobe = 1'b0;                // Address held while busy
    check_value("o_busy", busy, 1);
    check_value("o_sdram.strobe", sdram.strobe, 1);
    check_value("o_sdram.write_n", sdram.write_n, !wr);
    check_value("o_sdram.addr", sdram.addr, addr[ADDR_W-1:0]);
    if (wr)
      check_value("o_sdram.wdata", sdram.wdata, data[DATA_W-1:0]);
    while (busy)
      @(negedge clk);
    check_value("SDRAM strobe count", strobe_count, strobes_before + 1);
    check_value("SDRAM ack count", ack_count, acks_before + 1);  // Busy held until ack
    if (!wr)
      check_value("o_rdata", rdata, expected);
    cpu_idle();
  endtask

  task automatic host_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] data, input logic [31:0] expected);
    host.wr   = wr;
    host.rd   = !wr;
    host.addr = addr;
    host.data = data[BYTE_W-1:0];
    @(negedge clk);
    host = '0;
    if (addr[31:24] == 8'hFF)
      check_value("o_cpu_control", cpu_control, expected[7:0]);
    else
    begin
      check_value("o_boot.addr", boot.addr, addr);
      if (wr)
      begin
        check_value("o_boot.write_rq", boot.write_rq, 1);
        check_value("o_boot.wdata", boot.wdata, data[BYTE_W-1:0]);
      end
      else
        check_value("o_boot.read_rq", boot.read_rq, 1);
      while (boot.read_rq || boot.write_rq)
        @(negedge clk);
      if (!wr)
        check_value("o_host_rdata", host_rdata, expected[7:0]);
    end
  endtask

  task automatic button_press(input int hold, input logic [31:0] expected);
    btn_reset_n = 1'b0;
    repeat (hold)
    begin
      @(negedge clk);
      check_value("o_sys_reset", sys_reset, 1);
    end
    btn_reset_n = 1'b1;
    @(negedge clk);
    check_value("o_sys_reset", sys_reset, 0);   // Released one cycle late
    check_value("o_cpu_control", cpu_control, expected[7:0]);
  endtask

  // ====================================================================
  // Main sequence
  // ====================================================================
  initial
  begin
    int   lines;
    int   hold_cycles;
    op_e  op;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] aux;
    cpu_idle();
    host        = '0;
    reset       = 1'b1;
    pll_locked  = 1'b0;
    btn_reset_n = 1'b1;
    for (int k = 0; k < 4 * MAX_LINES; k++)
      stim[k] = 32'hF;
    $readmemh("test/stim_input.txt", stim);
    lines = 0;
    while (lines < MAX_LINES && stim[4*lines][3:0] != OP_END)
      lines = lines + 1;
    cycle_limit = RESET_CYCLES + 40 * lines;

    repeat (4) @(posedge clk);
    @(negedge clk);
    reset       = 1'b0;
    pll_locked  = 1'b1;
    hold_cycles = 0;
    while (sys_reset)
    begin
      @(negedge clk);
      if (sys_reset)
        hold_cycles = hold_cycles + 1;
    end
    check_value("o_sys_reset hold past delay", hold_cycles >= (1 << (DELAY_BITS - 1)), 1);
    check_value("o_busy", busy, 0);
    check_value("o_sdram.strobe", sdram.strobe, 0);
    check_value("o_boot.read_rq", boot.read_rq, 0);
    check_value("o_boot.write_rq", boot.write_rq, 0);
    check_value("o_cpu_control", cpu_control, 0);

    for (int i = 0; i < lines; i++)
    begin
      op   = op_e'(stim[4*i][3:0]);
      addr = stim[4*i+1];
      data = stim[4*i+2];
      aux  = stim[4*i+3];
      case (op)
        OP_CPU_WR:  cpu_access(1'b1, addr, data, aux);
        OP_CPU_RD:  cpu_access(1'b0, addr, data, aux);
        OP_SD_WR:   sdram_access(1'b1, addr, data, aux);
        OP_SD_RD:   sdram_access(1'b0, addr, data, aux);
        OP_HOST_WR: host_access(1'b1, addr, data, aux);
        OP_HOST_RD: host_access(1'b0, addr, data, aux);
        OP_BUTTON:  button_press(int'(data), aux);
        default:
        begin
          $display("Stimulus line %0d holds an unknown opcode %0h", i, stim[4*i]);
          $display("=== FAIL ===");
          $fatal(1, "bad stimulus file");
        end
      endcase
    end

    repeat (2) @(negedge clk);
    $display("=== PASS ===");
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/ti_mem_subsys_assert.sv ====
// Bound into ti_mem_subsys; all checks idle while the system reset is high
`timescale 1ns/1ps
`default_nettype none

module ti_mem_subsys_assert
(
  input logic                clk,
  input logic                i_reset,
  input bus_pkg::sdram_req_t i_sdram,
  input bus_pkg::boot_req_t  i_boot,
  input logic                i_boot_rd_ack,
  input logic                i_boot_wr_ack,
  input logic                i_busy
);
  import mem_map_pkg::*;

  int busy_run;  // Consecutive busy cycles

  always_ff @(posedge clk)
  begin
    if (i_reset || !i_busy)
      busy_run <= 0;
    else
      busy_run <= busy_run + 1;
  end

  // ====================================================================
  // Handshake properties
  // ====================================================================
  strobe_pulse: assert property (@(posedge clk) disable iff (i_reset)
    i_sdram.strobe |=> !i_sdram.strobe)
    else $error("SDRAM strobe longer than one cycle");

  read_rq_held: assert property (@(posedge clk) disable iff (i_reset)
    (i_boot.read_rq && !i_boot_rd_ack) |=> i_boot.read_rq)
    else $error("Read request dropped before its acknowledge");

  write_rq_held: assert property (@(posedge clk) disable iff (i_reset)
    (i_boot.write_rq && !i_boot_wr_ack) |=> i_boot.write_rq)
    else $error("Write request dropped before its acknowledge");

  busy_bound: assert property (@(posedge clk) disable iff (i_reset)
    busy_run <= SDRAM_WAIT_LIMIT + 1)  // Timeout plus the start cycle
    else $error("Busy held past the SDRAM timeout");

endmodule

bind ti_mem_subsys ti_mem_subsys_assert i_ti_mem_subsys_assert (
  .clk           (clk),
  .i_reset       (o_sys_reset),
  .i_sdram       (o_sdram),
  .i_boot        (o_boot),
  .i_boot_rd_ack (i_boot_rd_ack),
  .i_boot_wr_ack (i_boot_wr_ack),
  .i_busy        (o_busy)
);

`default_nettype wire
